// File: tb/elink_vectors.txt
// Columns write datamode ctrlmode dstaddr data srcaddr expected_read_word
// ctrlmode holds the test number and write rows expect 0
1 2 2 80800000 11223344 00000100 00000000
1 2 2 8080003c cafe0001 00000104 00000000
0 2 2 80800000 00000000 00000108 11223344
0 2 2 8080003c 00000000 0000010c cafe0001
1 0 3 80800001 000000aa 00000200 00000000
1 1 3 80800002 0000beef 00000204 00000000
0 2 3 80800000 00000000 00000208 beefaa44
0 1 4 8080003c 00000000 00000300 cafe0001
0 2 4 80800000 00000000 00000304 beefaa44
1 2 5 90800000 deadbeef 00000400 00000000
0 2 5 70800014 00000000 00000404 00000000
0 2 5 80800000 00000000 00000408 beefaa44
1 2 6 80800020 60000001 00000500 00000000
1 3 6 80800024 60000002 00000504 00000000
1 2 6 80800028 60000003 00000508 00000000
0 2 6 80800020 00000000 0000050c 60000001
0 2 6 80800024 00000000 00000510 60000002
0 2 6 80800028 00000000 00000514 60000003

// File: project.f
+incdir+design
design/elink_pkg.sv
design/tx_link_fsm.sv
design/link_byte_counter.sv
design/tx_shifter.sv
design/rx_deframer.sv
design/remote_mem.sv
design/elink_top.sv
tb/tb_elink.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the elink testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_elink -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_elink)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1

// File: tb/tb_elink.sv
`include "elink_params.svh"

module tb_elink
   import elink_pkg::*;
();

   localparam int MAX_VEC = 32;
   localparam int COLS    = 7;  // write datamode ctrlmode dstaddr data srcaddr expected

   logic       clk = 1'b0;
   logic       rst_n;
   logic       ext_access;
   elink_pkt_t ext_pkt;
   logic       rsp_wait;
   logic       wr_wait;
   logic       rd_wait;
   logic       rsp_access;
   elink_pkt_t rsp_pkt;

   logic [31:0] vec_mem [MAX_VEC*COLS];  // Flat vector table
   int          nvec;
   int          cycles      = 0;
   int          cycle_limit = 0;  // Zero until vectors are counted
   int          checks      = 0;
   int          errs        = 0;
   int          test_base   = 0;  // Errors before the current test
   int          tests       = 0;

   elink_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .ext_access (ext_access),
      .ext_pkt    (ext_pkt),
      .rsp_wait   (rsp_wait),
      .wr_wait    (wr_wait),
      .rd_wait    (rd_wait),
      .rsp_access (rsp_access),
      .rsp_pkt    (rsp_pkt)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout, run did not finish within %0d cycles", cycle_limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errs++;
         $display("ERR %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic finish_test(input int id);
      $display("test %0d done with %0d errors", id, errs - test_base);
      test_base = errs;
      tests++;
   endtask

   // Offer one packet and hold it until its wait is low at an edge
   task automatic send_packet(input int v);
      ext_pkt.write    = vec_mem[v*COLS][0];
      ext_pkt.datamode = datamode_e'(vec_mem[v*COLS+1][1:0]);
      ext_pkt.ctrlmode = vec_mem[v*COLS+2][3:0];
      ext_pkt.dstaddr  = vec_mem[v*COLS+3];
      ext_pkt.data     = vec_mem[v*COLS+4];
      ext_pkt.srcaddr  = vec_mem[v*COLS+5];
      ext_pkt.pad      = 1'b0;
      ext_access       = 1'b1;
      while (ext_pkt.write ? wr_wait : rd_wait) begin
         @(negedge clk);  // Waits come from registers and are stable here
      end
      @(posedge clk);  // Accept edge
      @(negedge clk);
      ext_access = 1'b0;
   endtask

   // Response to a read that hits, entered at the first negedge after accept
   task automatic take_response(input int v, input int hold);
      elink_pkt_t seen;
      int         lat;
      lat = 1;
      while (!rsp_access && lat < 40) begin
         @(negedge clk);
         lat++;
      end
      if (!rsp_access) begin
         errs++;
         $display("no response arrived for read vector %0d", v);
      end else begin
         seen = rsp_pkt;
         compare_value("rsp_latency", lat, 15);  // 13 link bytes then arrival then response
         compare_value("rsp_pkt.data", seen.data, vec_mem[v*COLS+6]);
         compare_value("rsp_pkt.dstaddr", seen.dstaddr, vec_mem[v*COLS+5]);
         compare_value("rsp_pkt.srcaddr", seen.srcaddr, vec_mem[v*COLS+3]);
         compare_value("rsp_pkt.write", 32'(seen.write), 32'd1);
         compare_value("rsp_pkt.datamode", 32'(seen.datamode), vec_mem[v*COLS+1]);
         compare_value("rsp_pkt.ctrlmode", 32'(seen.ctrlmode), vec_mem[v*COLS+2]);
         repeat (hold) begin
            @(negedge clk);  // Stalled by rsp_wait
            compare_value("rsp_access", 32'(rsp_access), 32'd1);
            compare_value("rd_wait", 32'(rd_wait), 32'd1);
            if (rsp_pkt !== seen) begin
               errs++;
               $display("response packet changed while rsp_wait was high");
            end
         end
         rsp_wait = 1'b0;
         @(negedge clk);
         compare_value("rsp_access", 32'(rsp_access), 32'd0);  // Left once
      end
   endtask

   // Read to a foreign core id must not come back
   task automatic expect_drop(input int v);
      int n;
      n = 1;
      while (rd_wait && n < 40) begin
         compare_value("rsp_access", 32'(rsp_access), 32'd0);
         @(negedge clk);
         n++;
      end
      compare_value("rsp_access", 32'(rsp_access), 32'd0);
      if (rd_wait) begin
         errs++;
         $display("rd_wait stayed high after dropped read vector %0d", v);
      end
   endtask

   initial begin
      int          v;
      int          test_id;
      int          hold;
      logic [31:0] dst;
      void'($urandom(32'h2f61));
      rst_n      = 1'b0;
      ext_access = 1'b0;
      ext_pkt    = '0;
      rsp_wait   = 1'b0;
      for (v = 0; v < MAX_VEC; v++) begin
         vec_mem[v*COLS] = 32'hffff_ffff;  // Marks rows past the file end
      end
      $readmemh("tb/elink_vectors.txt", vec_mem);
      nvec = 0;
      while (nvec < MAX_VEC && vec_mem[nvec*COLS] <= 32'd1) begin
         nvec++;
      end
      cycle_limit = nvec * 40 + 200;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      compare_value("wr_wait", 32'(wr_wait), 32'd0);
      compare_value("rd_wait", 32'(rd_wait), 32'd0);
      compare_value("rsp_access", 32'(rsp_access), 32'd0);
      test_id = 1;  // Test 1 is the reset check and vectors carry 2 and up
      for (v = 0; v < nvec; v++) begin
         if (int'(vec_mem[v*COLS+2]) != test_id) begin
            finish_test(test_id);
            test_id = int'(vec_mem[v*COLS+2]);
         end
         hold = 0;
         if (test_id == 4) begin
            hold     = 1 + int'($urandom % 8);  // Stall length
            rsp_wait = 1'b1;
         end
         dst = vec_mem[v*COLS+3];
         send_packet(v);
         if (vec_mem[v*COLS] == 32'd0) begin
            if (dst[31:20] == `ELINK_COREID) begin
               take_response(v, hold);
            end else begin
               expect_drop(v);
            end
         end
         rsp_wait = 1'b0;
      end
      finish_test(test_id);
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errs);
      if (errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: design/elink_top.sv
module elink_top
   import elink_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       ext_access,  // Packet strobe
   input  elink_pkt_t ext_pkt,
   input  logic       rsp_wait,    // Response stall
   output logic       wr_wait,
   output logic       rd_wait,
   output logic       rsp_access,
   output elink_pkt_t rsp_pkt
);

   logic       load;
   logic       step;
   logic       last;
   logic       link_frame;  // Link frame strobe
   logic [7:0] link_data;   // Link byte
   logic       rx_valid;
   elink_pkt_t rx_pkt;
   logic       rsp_pending;
   logic       read_dropped;

   // Transmit side
   tx_link_fsm u_tx_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .ext_access   (ext_access),
      .ext_write    (ext_pkt.write),  // Picks wr or rd wait
      .rsp_pending  (rsp_pending),
      .read_dropped (read_dropped),
      .last         (last),
      .wr_wait      (wr_wait),
      .rd_wait      (rd_wait),
      .load         (load),
      .step         (step),
      .link_frame   (link_frame)
   );

   link_byte_counter u_byte_cnt (
      .clk   (clk),
      .rst_n (rst_n),
      .load  (load),
      .step  (step),
      .last  (last)
   );

   tx_shifter u_tx_shift (
      .clk       (clk),
      .rst_n     (rst_n),
      .load      (load),
      .step      (step),
      .ext_pkt   (ext_pkt),
      .link_data (link_data)
   );

   // Far side of the link
   rx_deframer u_rx_deframe (
      .clk        (clk),
      .rst_n      (rst_n),
      .link_frame (link_frame),
      .link_data  (link_data),
      .rx_valid   (rx_valid),
      .rx_pkt     (rx_pkt)
   );

   remote_mem u_remote_mem (
      .clk          (clk),
      .rst_n        (rst_n),
      .rx_valid     (rx_valid),
      .rx_pkt       (rx_pkt),
      .rsp_wait     (rsp_wait),
      .rsp_pending  (rsp_pending),
      .rsp_access   (rsp_access),
      .rsp_pkt      (rsp_pkt),
      .read_dropped (read_dropped)
   );

endmodule

// File: design/remote_mem.sv
module remote_mem
   import elink_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx_valid,      // Packet arrived this cycle
   input  elink_pkt_t rx_pkt,
   input  logic       rsp_wait,      // Hold the response
   output logic       rsp_pending,   // Response held
   output logic       rsp_access,
   output elink_pkt_t rsp_pkt,
   output logic       read_dropped   // Read missed the core id
);

   localparam int IDX_W = $clog2(`ELINK_MEM_WORDS);
   localparam int DW    = `ELINK_ADDR_W;

   logic [DW-1:0]    mem [`ELINK_MEM_WORDS];
   logic             hit;
   logic             wr_en;
   logic             rd_en;
   logic [IDX_W-1:0] idx;
   logic [3:0]       lane_en;  // Byte lanes to update
   logic [DW-1:0]    wr_data;  // Data replicated onto the lanes

   assign hit = (rx_pkt.dstaddr[DW-1 -: `ELINK_COREID_W] == `ELINK_COREID);
   assign idx = rx_pkt.dstaddr[IDX_W+1:2];  // Word address

   assign wr_en        = rx_valid & hit & rx_pkt.write;
   assign rd_en        = rx_valid & hit & ~rx_pkt.write;
   assign read_dropped = rx_valid & ~hit & ~rx_pkt.write;

   // Lane select by access size
   always_comb begin
      case (rx_pkt.datamode)
         dm_byte: begin
            lane_en = 4'b0001 << rx_pkt.dstaddr[1:0];
            wr_data = {4{rx_pkt.data[7:0]}};
         end
         dm_half: begin
            lane_en = rx_pkt.dstaddr[1] ? 4'b1100 : 4'b0011;
            wr_data = {2{rx_pkt.data[15:0]}};
         end
         default: begin  // Word and double
            lane_en = 4'b1111;
            wr_data = rx_pkt.data;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int w = 0; w < `ELINK_MEM_WORDS; w++) mem[w] <= '0;
      end else if (wr_en) begin
         for (int i = 0; i < 4; i++) begin
            if (lane_en[i]) mem[idx][i*8 +: 8] <= wr_data[i*8 +: 8];
         end
      end
   end

   // Response valid, released on a free cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_access <= 1'b0;
      end else if (rd_en) begin
         rsp_access <= 1'b1;
      end else if (rsp_access && !rsp_wait) begin
         rsp_access <= 1'b0;
      end
   end

   // Response payload, addresses swapped for the return trip
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rsp_pkt.write    <= 1'b1;
         rsp_pkt.datamode <= rx_pkt.datamode;
         rsp_pkt.ctrlmode <= rx_pkt.ctrlmode;
         rsp_pkt.dstaddr  <= rx_pkt.srcaddr;
         rsp_pkt.data     <= mem[idx];  // Whole word regardless of size
         rsp_pkt.srcaddr  <= rx_pkt.dstaddr;
         rsp_pkt.pad      <= 1'b0;
      end
   end

   assign rsp_pending = rsp_access;

endmodule

// File: design/rx_deframer.sv
module rx_deframer
   import elink_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       link_frame,  // High while bytes arrive
   input  logic [7:0] link_data,
   output logic       rx_valid,    // One cycle after the last byte
   output elink_pkt_t rx_pkt
);

   localparam int PKT_W = `ELINK_LINK_BYTES * 8;

   logic [PKT_W-1:0] shift_q;  // Assembled bytes, oldest at the top
   logic             frame_q;  // Frame seen last cycle

   // Byte assembly, payload only
   always_ff @(posedge clk) begin
      if (link_frame) begin
         shift_q <= {shift_q[PKT_W-9:0], link_data};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         frame_q <= 1'b0;
      end else begin
         frame_q <= link_frame;
      end
   end

   // Falling frame marks a complete packet
   assign rx_valid = frame_q & ~link_frame;

   // Register holds still while frame is low
   assign rx_pkt = elink_pkt_t'(shift_q);

endmodule

// File: design/tx_shifter.sv
module tx_shifter
   import elink_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       load,       // Capture ext_pkt
   input  logic       step,       // Move next byte to the top
   input  elink_pkt_t ext_pkt,
   output logic [7:0] link_data   // Byte on the link
);

   localparam int PKT_W = `ELINK_LINK_BYTES * 8;

   logic [PKT_W-1:0] shift_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         shift_q <= '0;  // Quiet link after reset
      end else if (load) begin
         shift_q <= ext_pkt;
      end else if (step) begin
         shift_q <= {shift_q[PKT_W-9:0], 8'h00};  // MSB byte first
      end
   end

   assign link_data = shift_q[PKT_W-1 -: 8];

endmodule

// File: design/link_byte_counter.sv
module link_byte_counter
   import elink_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic load,  // Start of a packet
   input  logic step,  // One byte sent
   output logic last   // Counter at zero
);

   link_cnt_t cnt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (load) begin
         cnt <= link_cnt_t'(`ELINK_LINK_BYTES - 1);  // Bytes left after the first
      end else if (step && cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign last = (cnt == '0);

endmodule

// File: design/tx_link_fsm.sv
module tx_link_fsm
   import elink_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic ext_access,    // Packet strobe from outside
   input  logic ext_write,     // Kind of the offered packet
   input  logic rsp_pending,   // Remote side holds a read response
   input  logic read_dropped,  // Remote side discarded a read
   input  logic last,          // Final link byte this cycle
   output logic wr_wait,
   output logic rd_wait,
   output logic load,          // Capture packet, start counter
   output logic step,          // Advance one byte
   output logic link_frame
);

   tx_state_e state;
   logic      read_outstanding;  // One read in flight
   logic      pend_q;            // rsp_pending last cycle
   logic      rsp_fall;
   logic      wr_accept;
   logic      rd_accept;

   // Waits from registered state only
   assign wr_wait = (state == tx_send);
   assign rd_wait = (state == tx_send) | read_outstanding;

   assign wr_accept = ext_access & ext_write & ~wr_wait;
   assign rd_accept = ext_access & ~ext_write & ~rd_wait;
   assign load      = wr_accept | rd_accept;

   assign step       = (state == tx_send);
   assign link_frame = (state == tx_send);  // Frame covers every byte cycle

   assign rsp_fall = pend_q & ~rsp_pending;  // Response has left

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= tx_idle;
      end else begin
         case (state)
            tx_idle: if (load) state <= tx_send;
            tx_send: if (last) state <= tx_idle;  // 13th byte done
            default: state <= tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         read_outstanding <= 1'b0;
         pend_q           <= 1'b0;
      end else begin
         pend_q <= rsp_pending;
         if (rd_accept) begin
            read_outstanding <= 1'b1;
         end else if (rsp_fall || read_dropped) begin
            read_outstanding <= 1'b0;  // Response gone or miss decided
         end
      end
   end

endmodule

// File: design/elink_pkg.sv
`include "elink_params.svh"

package elink_pkg;

   // Transfer size of an access
   typedef enum logic [1:0] {
      dm_byte   = 2'd0,  // 8 bit
      dm_half   = 2'd1,  // 16 bit
      dm_word   = 2'd2,  // 32 bit
      dm_double = 2'd3   // Treated as word here
   } datamode_e;

   // One packet, MSB first on the link
   typedef struct packed {
      logic                     write;     // 1 write, 0 read
      datamode_e                datamode;  // Access size
      logic [3:0]               ctrlmode;  // Passed through untouched
      logic [`ELINK_ADDR_W-1:0] dstaddr;   // Target address
      logic [`ELINK_ADDR_W-1:0] data;      // Write data or read data
      logic [`ELINK_ADDR_W-1:0] srcaddr;   // Return address for reads
      logic                     pad;       // Fills the last link byte
   } elink_pkt_t;

   // Transmit FSM states
   typedef enum logic {
      tx_idle = 1'b0,  // Ready for a packet
      tx_send = 1'b1   // Bytes going out on the link
   } tx_state_e;

   // Link byte counter
   typedef logic [$clog2(`ELINK_LINK_BYTES)-1:0] link_cnt_t;

endpackage

// File: design/elink_params.svh
`ifndef ELINK_PARAMS_SVH
`define ELINK_PARAMS_SVH

// Address and data width of the packet fields
`define ELINK_ADDR_W 32

// Link bytes per packet, 104 packet bits over a byte-wide link
`define ELINK_LINK_BYTES 13

// Depth of the remote word memory
`define ELINK_MEM_WORDS 16

// Core id of the remote side, compared with dstaddr[31:20]
`define ELINK_COREID 12'h808

// Width of the core id field at the top of dstaddr
`define ELINK_COREID_W 12

`endif
